// File: src.f
logic/soc_pkg.sv
logic/mem_bus_if.sv
logic/region_decoder.sv
logic/irq_encoder.sv
logic/local_ram.sv
logic/shared_ram_arbiter.sv
logic/shared_ram.sv
logic/frame_fetch.sv
logic/soc_top.sv
tests/soc_tb.sv

// File: Bender.yml
package:
  name: soc_bus_subsystem

sources:
  - logic/soc_pkg.sv
  - logic/mem_bus_if.sv
  - logic/region_decoder.sv
  - logic/irq_encoder.sv
  - logic/local_ram.sv
  - logic/shared_ram_arbiter.sv
  - logic/shared_ram.sv
  - logic/frame_fetch.sv
  - logic/soc_top.sv
  - target: test
    files:
      - tests/soc_tb.sv

// File: tests/soc_tb.sv
`timescale 1ns/1ps

module soc_tb;

  localparam int BUS_TIMEOUT = 64;
  localparam int FETCH_TIMEOUT = 2000;
  localparam int RAND_OPS = 40;

  logic sysclock;
  logic rst_i;
  soc_pkg::addr_t cpu_adr_i;
  soc_pkg::word_t cpu_dat_i;
  logic cpu_we_i;
  soc_pkg::sel_t cpu_sel_i;
  logic cpu_cyc_i;
  soc_pkg::word_t cpu_dat_o;
  logic cpu_ack_o;
  logic int_en_i;
  soc_pkg::irq_lines_t irq_lines_i;
  soc_pkg::irq_code_t cpu_irq_o;
  logic fault_o;
  logic fetch_start_i;
  soc_pkg::addr_t fetch_base_i;
  soc_pkg::word_t pixel_o;
  logic pixel_valid_o;
  logic fetch_busy_o;

  soc_pkg::word_t local_model [soc_pkg::LOCAL_WORDS];
  soc_pkg::word_t shared_model [soc_pkg::SHARED_WORDS];
  int err_count;
  logic check_on;
  logic exp_fault;

  soc_top UUT (.*);

  always #2 sysclock = ~sysclock;

  // only regions 1 and 6 are mapped
  assign exp_fault = cpu_cyc_i && !(cpu_adr_i[31:28] == 4'h1 || cpu_adr_i[31:28] == 4'h6);

  function automatic soc_pkg::irq_code_t expected_irq(input logic en, input logic fault,
                                                      input soc_pkg::irq_lines_t lines);
    soc_pkg::irq_code_t code;
    code = 3'd0;
    // walk upward so the highest active line wins
    for (int b = 0; b < 6; b++) begin
      if (lines[b]) begin
        case (b)
          0: code = 3'd7; // uart tx
          1: code = 3'd6; // uart rx
          default: code = 3'(b); // timer0..timer3
        endcase
      end
    end
    if (fault)
      code = 3'd1;
    if (!en)
      code = 3'd0;
    return code;
  endfunction

  function automatic soc_pkg::word_t merge_bytes(input soc_pkg::word_t old_w,
                                                 input soc_pkg::word_t new_w,
                                                 input soc_pkg::sel_t sel);
    soc_pkg::word_t res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (sel[b])
        res[8*b +: 8] = new_w[8*b +: 8];
    end
    return res;
  endfunction

  // junk in the middle bits, the RAMs only look at the word index
  function automatic soc_pkg::addr_t local_addr(input int idx);
    return {4'h1, 21'($urandom), 5'(idx), 2'b00};
  endfunction

  function automatic soc_pkg::addr_t shared_addr(input int idx);
    return {4'h6, 18'($urandom), 8'(idx), 2'b00};
  endfunction

  task automatic compare_values(input logic [31:0] actual, input logic [31:0] expected,
                                input string what);
    if (actual !== expected) begin
      err_count++;
      $display("MISMATCH at %0t: %s, got %h, expected %h", $time, what, actual, expected);
      $display("Test failures found");
      $fatal(1, "stopping at first error");
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout at %0t: %s never happened", $time, what);
    $display("Test failures found");
    $fatal(1, "stopping on timeout");
  endtask

  // call on a falling edge, returns there too
  task automatic cpu_access(input soc_pkg::addr_t adr, input logic we,
                            input soc_pkg::word_t wdat, input soc_pkg::sel_t sel,
                            output soc_pkg::word_t rdat, output int cycles);
    cpu_adr_i = adr;
    cpu_we_i = we;
    cpu_dat_i = wdat;
    cpu_sel_i = sel;
    cpu_cyc_i = 1'b1;
    cycles = 0;
    do begin
      @(negedge sysclock);
      cycles++;
      if (cycles > BUS_TIMEOUT)
        report_timeout("cpu_ack_o for a CPU bus access");
    end while (!cpu_ack_o);
    rdat = cpu_dat_o;
    cpu_cyc_i = 1'b0;
    cpu_we_i = 1'b0;
    @(negedge sysclock); // cyc low for a cycle
  endtask

  // fault and interrupt code, checked every cycle
  always @(posedge sysclock) begin
    if (check_on) begin
      compare_values(fault_o, exp_fault, "fault_o");
      compare_values(cpu_irq_o, expected_irq(int_en_i, exp_fault, irq_lines_i), "cpu_irq_o");
    end
  end

  initial begin
    soc_pkg::word_t rd;
    soc_pkg::word_t wd;
    soc_pkg::sel_t sel;
    logic [3:0] region;
    int cycles;
    int idx;
    int base_idx;
    int pix_cnt;
    int wait_cnt;
    void'($urandom(32'h3333));
    err_count = 0;
    check_on = 1'b0;
    sysclock = 1'b0;
    rst_i = 1'b1;
    cpu_adr_i = '0;
    cpu_dat_i = '0;
    cpu_we_i = 1'b0;
    cpu_sel_i = '0;
    cpu_cyc_i = 1'b0;
    int_en_i = 1'b0;
    irq_lines_i = '0;
    fetch_start_i = 1'b0;
    fetch_base_i = '0;
    repeat (2) @(negedge sysclock);
    rst_i = 1'b0;
    compare_values(cpu_ack_o, 0, "cpu_ack_o after reset");
    compare_values(pixel_valid_o, 0, "pixel_valid_o after reset");
    compare_values(fetch_busy_o, 0, "fetch_busy_o after reset");
    check_on = 1'b1;

    // local RAM: full fill, then partial writes each read back
    for (int i = 0; i < soc_pkg::LOCAL_WORDS; i++) begin
      wd = $urandom;
      cpu_access(local_addr(i), 1'b1, wd, 4'hf, rd, cycles);
      local_model[i] = wd;
    end
    for (int i = 0; i < RAND_OPS; i++) begin
      idx = $urandom % soc_pkg::LOCAL_WORDS;
      wd = $urandom;
      sel = 4'($urandom);
      cpu_access(local_addr(idx), 1'b1, wd, sel, rd, cycles);
      compare_values(cycles, 2, "local RAM write ack latency");
      local_model[idx] = merge_bytes(local_model[idx], wd, sel);
      cpu_access(local_addr(idx), 1'b0, $urandom, 4'($urandom), rd, cycles);
      compare_values(cycles, 2, "local RAM read ack latency");
      compare_values(rd, local_model[idx], "local RAM read data");
    end

    // shared RAM, same pattern
    for (int i = 0; i < soc_pkg::SHARED_WORDS; i++) begin
      wd = $urandom;
      cpu_access(shared_addr(i), 1'b1, wd, 4'hf, rd, cycles);
      shared_model[i] = wd;
    end
    for (int i = 0; i < RAND_OPS; i++) begin
      idx = $urandom % soc_pkg::SHARED_WORDS;
      wd = $urandom;
      sel = 4'($urandom);
      cpu_access(shared_addr(idx), 1'b1, wd, sel, rd, cycles);
      shared_model[idx] = merge_bytes(shared_model[idx], wd, sel);
      cpu_access(shared_addr(idx), 1'b0, $urandom, 4'($urandom), rd, cycles);
      compare_values(rd, shared_model[idx], "shared RAM read data");
    end

    // unmapped regions, fault must win the interrupt
    int_en_i = 1'b1;
    for (int i = 0; i < 12; i++) begin
      do
        region = 4'($urandom);
      while (region == 4'h1 || region == 4'h6);
      irq_lines_i = 6'($urandom);
      cpu_access({region, 28'($urandom)}, 1'($urandom), $urandom, 4'hf, rd, cycles);
      compare_values(cycles, 1, "error ack latency");
      compare_values(rd, 0, "error access read data");
    end

    // interrupt lines alone, enable toggling
    for (int i = 0; i < 64; i++) begin
      @(negedge sysclock);
      irq_lines_i = 6'($urandom) & 6'($urandom);
      if (i % 4 == 0)
        int_en_i = ~int_en_i;
    end

    // frame fetch racing CPU reads on the shared RAM
    base_idx = $urandom % soc_pkg::SHARED_WORDS;
    fork
      begin
        fetch_base_i = {4'h6, 18'd0, 8'(base_idx), 2'b00};
        fetch_start_i = 1'b1;
        @(negedge sysclock);
        fetch_start_i = 1'b0;
        compare_values(fetch_busy_o, 1, "fetch_busy_o after start");
        pix_cnt = 0;
        wait_cnt = 0;
        do begin
          @(negedge sysclock);
          wait_cnt++;
          if (wait_cnt > FETCH_TIMEOUT)
            report_timeout("fetch_busy_o falling at the end of the fetch");
          if (pixel_valid_o) begin
            compare_values(pixel_o, shared_model[(base_idx + pix_cnt) % soc_pkg::SHARED_WORDS],
                           "pixel data");
            pix_cnt++;
          end
        end while (fetch_busy_o);
        compare_values(pix_cnt, soc_pkg::FETCH_WORDS, "pixel count");
      end
      begin
        for (int i = 0; i < 10; i++) begin
          repeat ($urandom % 6) @(negedge sysclock); // spread the reads out
          idx = $urandom % soc_pkg::SHARED_WORDS;
          cpu_access(shared_addr(idx), 1'b0, '0, 4'hf, rd, cycles);
          compare_values(rd, shared_model[idx], "CPU read during fetch");
        end
      end
    join

    @(negedge sysclock);
    compare_values(fetch_busy_o, 0, "fetch_busy_o after fetch");
    if (err_count == 0) begin
      $display("All tests passed!");
      $finish;
    end else begin
      $display("Test failures found");
      $fatal(1, "run ended with errors");
    end
  end

endmodule

// File: logic/soc_top.sv
`timescale 1ns/1ps

module soc_top (
  input logic sysclock,
  input logic rst_i,
  input soc_pkg::addr_t cpu_adr_i,
  input soc_pkg::word_t cpu_dat_i,
  input logic cpu_we_i,
  input soc_pkg::sel_t cpu_sel_i,
  input logic cpu_cyc_i,
  output soc_pkg::word_t cpu_dat_o,
  output logic cpu_ack_o,
  input logic int_en_i,
  input soc_pkg::irq_lines_t irq_lines_i,
  output soc_pkg::irq_code_t cpu_irq_o,
  output logic fault_o,
  input logic fetch_start_i,
  input soc_pkg::addr_t fetch_base_i,
  output soc_pkg::word_t pixel_o,
  output logic pixel_valid_o,
  output logic fetch_busy_o
);

  mem_bus_if cpu_local ();
  mem_bus_if cpu_shared ();
  mem_bus_if fetch_bus ();
  mem_bus_if ram_bus ();

  soc_pkg::region_t region;
  logic err_ack;
  logic sel_local, sel_shared, sel_none;

  region_decoder u_region_decoder (
    .sysclock (sysclock),
    .rst_i (rst_i),
    .adr_i (cpu_adr_i),
    .cyc_i (cpu_cyc_i),
    .region_o (region),
    .fault_o (fault_o),
    .err_ack_o (err_ack)
  );

  irq_encoder u_irq_encoder (
    .int_en_i (int_en_i),
    .fault_i (fault_o),
    .lines_i (irq_lines_i),
    .irq_o (cpu_irq_o)
  );

  assign sel_local = (region == soc_pkg::REGION_LOCAL);
  assign sel_shared = (region == soc_pkg::REGION_SHARED);
  assign sel_none = (region == soc_pkg::REGION_NONE);

  // cpu request fans out to both paths, stb picks one
  assign cpu_local.adr = cpu_adr_i;
  assign cpu_local.wdat = cpu_dat_i;
  assign cpu_local.we = cpu_we_i;
  assign cpu_local.sel = cpu_sel_i;
  assign cpu_local.cyc = cpu_cyc_i;
  assign cpu_local.stb = cpu_cyc_i & sel_local;

  assign cpu_shared.adr = cpu_adr_i;
  assign cpu_shared.wdat = cpu_dat_i;
  assign cpu_shared.we = cpu_we_i;
  assign cpu_shared.sel = cpu_sel_i;
  assign cpu_shared.cyc = cpu_cyc_i;
  assign cpu_shared.stb = cpu_cyc_i & sel_shared;

  // error access contributes no data
  assign cpu_dat_o = (sel_local ? cpu_local.rdat : '0) |
                     (sel_shared ? cpu_shared.rdat : '0);
  assign cpu_ack_o = (sel_local & cpu_local.ack) |
                     (sel_shared & cpu_shared.ack) |
                     (sel_none & err_ack);

  local_ram u_local_ram (
    .sysclock (sysclock),
    .rst_i (rst_i),
    .bus (cpu_local)
  );

  shared_ram_arbiter u_arbiter (
    .sysclock (sysclock),
    .rst_i (rst_i),
    .cpu (cpu_shared),
    .fetch (fetch_bus),
    .ram (ram_bus)
  );

  shared_ram u_shared_ram (
    .sysclock (sysclock),
    .rst_i (rst_i),
    .bus (ram_bus)
  );

  frame_fetch u_frame_fetch (
    .sysclock (sysclock),
    .rst_i (rst_i),
    .start_i (fetch_start_i),
    .base_i (fetch_base_i),
    .bus (fetch_bus),
    .pixel_o (pixel_o),
    .pixel_valid_o (pixel_valid_o),
    .busy_o (fetch_busy_o)
  );

endmodule

// File: logic/frame_fetch.sv
`timescale 1ns/1ps

module frame_fetch (
  input logic sysclock,
  input logic rst_i,
  input logic start_i,
  input soc_pkg::addr_t base_i,
  mem_bus_if.master bus,
  output soc_pkg::word_t pixel_o,
  output logic pixel_valid_o,
  output logic busy_o
);

  typedef enum logic [1:0] {
    FETCH_IDLE,
    FETCH_REQ,
    FETCH_GAP
  } fetch_state_t;

  fetch_state_t state;
  logic [soc_pkg::FETCH_CNT_W-1:0] count_q;
  soc_pkg::addr_t addr_q;

  assign busy_o = (state != FETCH_IDLE);

  // read only master
  assign bus.adr = addr_q;
  assign bus.wdat = '0;
  assign bus.we = 1'b0;
  assign bus.sel = '1;
  assign bus.cyc = (state == FETCH_REQ);
  assign bus.stb = (state == FETCH_REQ);

  always_ff @(posedge sysclock or posedge rst_i) begin
    if (rst_i) begin
      state <= FETCH_IDLE;
      count_q <= '0;
      addr_q <= '0;
      pixel_valid_o <= 1'b0;
    end else begin
      pixel_valid_o <= 1'b0;
      case (state)
        FETCH_IDLE: begin
          if (start_i) begin
            addr_q <= base_i;
            count_q <= '0;
            state <= FETCH_REQ;
          end
        end
        FETCH_REQ: begin
          if (bus.ack) begin
            pixel_valid_o <= 1'b1;
            count_q <= count_q + 1'b1;
            addr_q <= addr_q + 32'd4;
            state <= (count_q == soc_pkg::FETCH_LAST) ? FETCH_IDLE : FETCH_GAP;
          end
        end
        FETCH_GAP: state <= FETCH_REQ; // cyc low for one cycle
        default: state <= FETCH_IDLE;
      endcase
    end
  end

  always_ff @(posedge sysclock) begin
    if (state == FETCH_REQ && bus.ack)
      pixel_o <= bus.rdat;
  end

endmodule

// File: logic/shared_ram.sv
`timescale 1ns/1ps

module shared_ram (
  input logic sysclock,
  input logic rst_i,
  mem_bus_if.slave bus
);

  soc_pkg::word_t mem [soc_pkg::SHARED_WORDS];
  logic [soc_pkg::SHARED_AW-1:0] idx;
  logic req;
  logic ack_q;
  logic served_q; // access already acked, wait for stb to drop
  logic wr_en;

  assign idx = bus.adr[soc_pkg::SHARED_AW+1:2];
  assign req = bus.cyc & bus.stb;
  assign wr_en = req & bus.we & ~ack_q & ~served_q;
  assign bus.ack = ack_q;

  always_ff @(posedge sysclock or posedge rst_i) begin
    if (rst_i) begin
      ack_q <= 1'b0;
      served_q <= 1'b0;
    end else begin
      ack_q <= req & ~ack_q & ~served_q;
      served_q <= req & (served_q | ack_q);
    end
  end

  always_ff @(posedge sysclock) begin
    if (wr_en) begin
      for (int b = 0; b < soc_pkg::SEL_W; b++) begin
        if (bus.sel[b])
          mem[idx][8*b +: 8] <= bus.wdat[8*b +: 8];
      end
    end
    if (req)
      bus.rdat <= mem[idx];
  end

endmodule

// File: logic/shared_ram_arbiter.sv
`timescale 1ns/1ps

module shared_ram_arbiter (
  input logic sysclock,
  input logic rst_i,
  mem_bus_if.slave cpu,
  mem_bus_if.slave fetch,
  mem_bus_if.master ram
);

  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_CPU,
    ARB_FETCH
  } arb_state_t;

  arb_state_t state, state_next;
  logic cpu_gnt, fetch_gnt;

  assign cpu_gnt = (state == ARB_CPU);
  assign fetch_gnt = (state == ARB_FETCH);

  always_comb begin
    state_next = state;
    case (state)
      ARB_IDLE: begin
        if (cpu.cyc && cpu.stb)
          state_next = ARB_CPU; // cpu wins a tie
        else if (fetch.cyc && fetch.stb)
          state_next = ARB_FETCH;
      end
      ARB_CPU, ARB_FETCH: begin
        if (ram.ack)
          state_next = ARB_IDLE;
      end
      default: state_next = ARB_IDLE;
    endcase
  end

  always_ff @(posedge sysclock or posedge rst_i) begin
    if (rst_i) begin
      state <= ARB_IDLE;
    end else begin
      state <= state_next;
    end
  end

  assign ram.adr = fetch_gnt ? fetch.adr : cpu.adr;
  assign ram.wdat = fetch_gnt ? fetch.wdat : cpu.wdat;
  assign ram.we = fetch_gnt ? fetch.we : cpu.we;
  assign ram.sel = fetch_gnt ? fetch.sel : cpu.sel;
  assign ram.cyc = (cpu_gnt & cpu.cyc) | (fetch_gnt & fetch.cyc);
  assign ram.stb = (cpu_gnt & cpu.stb) | (fetch_gnt & fetch.stb);

  // returns only reach the granted side
  assign cpu.ack = cpu_gnt & ram.ack;
  assign fetch.ack = fetch_gnt & ram.ack;
  assign cpu.rdat = cpu_gnt ? ram.rdat : '0;
  assign fetch.rdat = fetch_gnt ? ram.rdat : '0;

endmodule

// File: logic/local_ram.sv
`timescale 1ns/1ps

module local_ram (
  input logic sysclock,
  input logic rst_i,
  mem_bus_if.slave bus
);

  soc_pkg::word_t mem [soc_pkg::LOCAL_WORDS];
  logic [soc_pkg::LOCAL_AW-1:0] idx;
  logic req;
  logic [1:0] ack_q;

  assign idx = bus.adr[soc_pkg::LOCAL_AW+1:2];
  assign req = bus.cyc & bus.stb;
  assign bus.ack = ack_q[1];

  // two edges from request to ack
  always_ff @(posedge sysclock or posedge rst_i) begin
    if (rst_i) begin
      ack_q <= 2'b00;
    end else if (!req) begin
      ack_q <= 2'b00;
    end else begin
      ack_q <= {ack_q[0], 1'b1};
    end
  end

  always_ff @(posedge sysclock) begin
    if (req && bus.we) begin
      for (int b = 0; b < soc_pkg::SEL_W; b++) begin
        if (bus.sel[b])
          mem[idx][8*b +: 8] <= bus.wdat[8*b +: 8];
      end
    end
    bus.rdat <= mem[idx];
  end

endmodule

// File: logic/irq_encoder.sv
`timescale 1ns/1ps

module irq_encoder (
  input logic int_en_i,
  input logic fault_i,
  input soc_pkg::irq_lines_t lines_i,
  output soc_pkg::irq_code_t irq_o
);

  always_comb begin
    irq_o = soc_pkg::IRQ_NONE;
    if (int_en_i) begin
      if (fault_i)
        irq_o = soc_pkg::IRQ_FAULT; // fault beats everything
      else if (lines_i[5])
        irq_o = soc_pkg::IRQ_TIMER3;
      else if (lines_i[4])
        irq_o = soc_pkg::IRQ_TIMER2;
      else if (lines_i[3])
        irq_o = soc_pkg::IRQ_TIMER1;
      else if (lines_i[2])
        irq_o = soc_pkg::IRQ_TIMER0;
      else if (lines_i[1])
        irq_o = soc_pkg::IRQ_UART_RX;
      else if (lines_i[0])
        irq_o = soc_pkg::IRQ_UART_TX;
    end
  end

endmodule

// File: logic/region_decoder.sv
`timescale 1ns/1ps

module region_decoder (
  input logic sysclock,
  input logic rst_i,
  input soc_pkg::addr_t adr_i,
  input logic cyc_i,
  output soc_pkg::region_t region_o,
  output logic fault_o,
  output logic err_ack_o
);

  soc_pkg::region_t adr_region;
  logic mapped;

  assign adr_region = adr_i[soc_pkg::REGION_MSB:soc_pkg::REGION_LSB];
  assign mapped = (adr_region == soc_pkg::REGION_LOCAL) ||
                  (adr_region == soc_pkg::REGION_SHARED);

  assign region_o = (cyc_i && mapped) ? adr_region : soc_pkg::REGION_NONE;
  assign fault_o = cyc_i & ~mapped;

  // single pulse, drops again even if cyc lingers
  always_ff @(posedge sysclock or posedge rst_i) begin
    if (rst_i) begin
      err_ack_o <= 1'b0;
    end else begin
      err_ack_o <= fault_o & ~err_ack_o;
    end
  end

endmodule

// File: logic/mem_bus_if.sv
`timescale 1ns/1ps

interface mem_bus_if;
  soc_pkg::addr_t adr;
  soc_pkg::word_t wdat;
  soc_pkg::word_t rdat;
  logic we;
  soc_pkg::sel_t sel;
  logic cyc;
  logic stb;
  logic ack;

  // request held steady until ack
  modport master (
    output adr, wdat, we, sel, cyc, stb,
    input rdat, ack
  );

  modport slave (
    input adr, wdat, we, sel, cyc, stb,
    output rdat, ack
  );

endinterface

// File: logic/soc_pkg.sv
package soc_pkg;

  localparam int WORD_W = 32;
  localparam int ADDR_W = 32;
  localparam int SEL_W = 4;
  localparam int REGION_MSB = 31;
  localparam int REGION_LSB = 28;

  typedef logic [WORD_W-1:0] word_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [SEL_W-1:0] sel_t;
  typedef logic [REGION_MSB-REGION_LSB:0] region_t;
  typedef logic [2:0] irq_code_t;
  typedef logic [5:0] irq_lines_t; // timer3..timer0, uart rx, uart tx

  localparam region_t REGION_NONE = 4'h0;
  localparam region_t REGION_LOCAL = 4'h1;
  localparam region_t REGION_SHARED = 4'h6;

  localparam int LOCAL_WORDS = 32;
  localparam int LOCAL_AW = 5;
  localparam int SHARED_WORDS = 256;
  localparam int SHARED_AW = 8;
  localparam int FETCH_WORDS = 16;
  localparam int FETCH_CNT_W = 4;
  localparam logic [FETCH_CNT_W-1:0] FETCH_LAST = FETCH_CNT_W'(FETCH_WORDS - 1);

  localparam irq_code_t IRQ_NONE = 3'h0;
  localparam irq_code_t IRQ_FAULT = 3'h1;
  localparam irq_code_t IRQ_TIMER0 = 3'h2;
  localparam irq_code_t IRQ_TIMER1 = 3'h3;
  localparam irq_code_t IRQ_TIMER2 = 3'h4;
  localparam irq_code_t IRQ_TIMER3 = 3'h5;
  localparam irq_code_t IRQ_UART_RX = 3'h6;
  localparam irq_code_t IRQ_UART_TX = 3'h7;

endpackage
